// ==== verilog.f ====
logic/riscv_isa_pkg.sv
logic/core_pkg.sv
logic/reg_file.sv
logic/decoder.sv
logic/alu.sv
logic/pipe_core.sv
dv/clk_gen.sv
dv/pipe_core_assert.sv
dv/tb_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and decide on the log contents.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_top -f verilog.f -o sim_tb \
    && ./obj_dir/sim_tb | tee sim.log \
    || { echo "build or run error"; exit 1; }

grep -q "^TEST OK$" sim.log && exit 0 || exit 1

// ==== dv/tb_top.sv ====
`timescale 1ns/1ns

module tb_top;
    import core_pkg::*;
    import riscv_isa_pkg::*;

    localparam instr_t NOP = 32'h0000_0013;

    logic     CLK;
    logic     RESET_N;
    pc_t      imem_addr;
    instr_t   imem_data;
    pc_t      dmem_addr;
    word_t    dmem_wdata;
    logic     dmem_we;
    word_t    dmem_rdata;

    logic [31:0] lfsr_state = 32'hb7f240ff;
    instr_t   prog [$];
    word_t    dmem [256];
    word_t    exp_addr [$];
    word_t    exp_data [$];
    reg_idx_t recent [2];
    int       store_idx = 0;
    pc_t      loop_addr;
    logic     gen_done = 1'b0;

    clk_gen i_clk_gen (.CLK(CLK), .RESET_N(RESET_N));

    pipe_core i_dut (
        .CLK        (CLK),
        .RESET_N    (RESET_N),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_we    (dmem_we),
        .dmem_rdata (dmem_rdata)
    );

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic instr_t enc_r(input logic [6:0] f7, input reg_idx_t rs2,
                                     input reg_idx_t rs1, input logic [2:0] f3,
                                     input reg_idx_t rd, input logic [6:0] op);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    function automatic instr_t enc_b(input logic [12:0] imm, input reg_idx_t rs2,
                                     input reg_idx_t rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
    endfunction

    // source must not be a destination of the last two instructions
    function reg_idx_t pick_src();
        reg_idx_t r;
        r = reg_idx_t'(rand_bits(5));
        while (r != 0 && (r == recent[0] || r == recent[1])) begin
            r = reg_idx_t'(rand_bits(5));
        end
        return r;
    endfunction

    function void push_dest(input reg_idx_t rd);
        recent[1] = recent[0];
        recent[0] = rd;
    endfunction

    task automatic gen_program();
        logic [2:0]  kind;
        logic [2:0]  f3;
        logic [11:0] imm12;
        logic [6:0]  f7;
        reg_idx_t    rd;
        reg_idx_t    rs1;
        reg_idx_t    rs2;
        while (prog.size() < 200) begin
            kind = 3'(rand_bits(3));
            f3   = 3'(rand_bits(3));
            rd   = reg_idx_t'(rand_bits(5));
            rs1  = pick_src();
            rs2  = pick_src();
            f7   = (rand_bits(1) && (f3 == F3_ADD_SUB || f3 == F3_SR)) ? F7_ALT : 7'd0;
            case (kind)
                3'd0, 3'd1: prog.push_back(enc_r(f7, rs2, rs1, f3, rd, OP_REG));
                3'd2, 3'd3: begin
                    imm12 = 12'(rand_bits(12));
                    // shifts keep a legal funct7
                    if (f3 == F3_SLL || f3 == F3_SR) begin
                        imm12 = (f3 == F3_SR) ? {f7, imm12[4:0]} : {7'd0, imm12[4:0]};
                    end
                    prog.push_back({imm12, rs1, f3, rd, OP_IMM});
                end
                3'd4: prog.push_back({20'(rand_bits(20)), rd, OP_LUI});
                3'd5: begin
                    imm12 = {2'b00, 8'(rand_bits(8)), 2'b00};
                    prog.push_back({imm12, 5'd0, F3_LW_SW, rd, OP_LOAD});
                end
                3'd6: begin
                    imm12 = {2'b00, 8'(rand_bits(8)), 2'b00};
                    prog.push_back({imm12[11:5], rs2, 5'd0, F3_LW_SW, imm12[4:0], OP_STORE});
                    rd = '0;
                end
                default: begin
                    prog.push_back(NOP);
                    prog.push_back(NOP);
                    prog.push_back(enc_b(rand_bits(1) ? 13'd12 : 13'd8, rs2, rs1,
                                         rand_bits(1) ? F3_BNE : F3_BEQ));
                    rd = '0;
                end
            endcase
            push_dest(rd);
        end
        repeat (3) prog.push_back(NOP);
        // dump every register to memory
        for (int r = 1; r < 32; r++) begin
            imm12 = 12'(r * 4);
            prog.push_back({imm12[11:5], reg_idx_t'(r), 5'd0, F3_LW_SW, imm12[4:0], OP_STORE});
        end
        repeat (2) prog.push_back(NOP);
        loop_addr = pc_t'(prog.size() * 4);
        prog.push_back(enc_b(13'd0, 5'd0, 5'd0, F3_BEQ));
    endtask

    function automatic word_t model_alu(input logic [2:0] f3, input logic sub_sra,
                                        input word_t a, input word_t b);
        case (f3)
            F3_ADD_SUB: return sub_sra ? a - b : a + b;
            F3_SLL:     return a << b[4:0];
            F3_SLT:     return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            F3_SLTU:    return (a < b) ? 32'd1 : 32'd0;
            F3_XOR:     return a ^ b;
            F3_SR:      return sub_sra ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            F3_OR:      return a | b;
            default:    return a & b;
        endcase
    endfunction

    task automatic run_model();
        word_t  regs [32];
        word_t  mem [256];
        instr_t ins;
        word_t  a;
        word_t  b;
        word_t  res;
        int     pc;
        int     steps;
        regs  = '{default: '0};
        mem   = dmem;
        pc    = 0;
        steps = 0;
        while (pc != int'(loop_addr >> 2) && steps < 10000) begin
            ins = prog[pc];
            a   = regs[ins[19:15]];
            b   = regs[ins[24:20]];
            res = '0;
            pc++;
            steps++;
            case (ins[6:0])
                OP_REG: res = model_alu(ins[14:12], ins[30], a, b);
                OP_IMM: res = model_alu(ins[14:12], ins[30] && ins[14:12] == F3_SR, a,
                                        {{20{ins[31]}}, ins[31:20]});
                OP_LUI: res = {ins[31:12], 12'd0};
                OP_LOAD: res = mem[(a + {{20{ins[31]}}, ins[31:20]}) >> 2 & 255];
                OP_STORE: begin
                    res = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                    exp_addr.push_back(res);
                    exp_data.push_back(b);
                    mem[res[9:2]] = b;
                end
                default: begin
                    if ((ins[14:12] == F3_BEQ) == (a == b)) begin
                        pc = pc - 1 + int'({ins[7], ins[30:25], ins[11:8]}) / 2;
                    end
                end
            endcase
            if (ins[6:0] inside {OP_REG, OP_IMM, OP_LUI, OP_LOAD} && ins[11:7] != 0) begin
                regs[ins[11:7]] = res;
            end
        end
    endtask

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h expected %h", name, got, exp);
            abort_run("store stream differs from the reference model");
        end
    endtask

    initial begin
        imem_data  = NOP;
        dmem_rdata = '0;
        recent     = '{default: '0};
        for (int i = 0; i < 256; i++) begin
            dmem[i] = rand_bits(32);
        end
        gen_program();
        run_model();
        gen_done = 1'b1;
    end

    // memories answer on the falling edge and take stores there too
    always @(negedge CLK) begin
        if (RESET_N && dmem_we) begin
            if (store_idx >= exp_addr.size()) begin
                abort_run("extra store seen after all expected stores");
            end else begin
                check_value("dmem_addr", dmem_addr, exp_addr[store_idx]);
                check_value("dmem_wdata", dmem_wdata, exp_data[store_idx]);
                dmem[dmem_addr[9:2]] = dmem_wdata;
                store_idx++;
            end
        end
        imem_data  <= ((imem_addr >> 2) < prog.size()) ? prog[imem_addr >> 2] : NOP;
        dmem_rdata <= dmem[dmem_addr[9:2]];
    end

    initial begin
        wait (gen_done);
        repeat (2 * prog.size() + 50) @(posedge CLK);
        abort_run("timeout before the program reached its final loop");
    end

    initial begin
        wait (gen_done);
        wait (RESET_N);
        wait (imem_addr == loop_addr);
        repeat (4) @(negedge CLK);
        if (store_idx != exp_addr.size()) begin
            abort_run($sformatf("final loop reached with %0d expected stores missing",
                                exp_addr.size() - store_idx));
        end else begin
            $display("TEST OK");
            $finish;
        end
    end

endmodule

// ==== dv/pipe_core_assert.sv ====
`timescale 1ns/1ns

module pipe_core_assert (
    input logic          CLK,
    input logic          RESET_N,
    input core_pkg::pc_t imem_addr,
    input logic          dmem_we,
    input logic          branch_taken
);
    // no store strobe while the pipeline is still empty
    a_we_in_reset: assert property (@(posedge CLK) !RESET_N |-> !dmem_we)
        else $error("dmem_we high during reset");

    a_we_after_reset: assert property (@(posedge CLK) $rose(RESET_N) |-> !dmem_we ##1 !dmem_we)
        else $error("dmem_we high in the first cycles after reset");

    a_pc_aligned: assert property (@(posedge CLK) imem_addr[1:0] == 2'b00)
        else $error("imem_addr not word aligned");

    // killed slot would reach memory two cycles after resolution
    a_flush_no_store: assert property (
        @(posedge CLK) disable iff (!RESET_N) branch_taken |-> ##2 !dmem_we)
        else $error("store from the flushed slot after a taken branch");

endmodule

bind pipe_core pipe_core_assert i_assert (
    .CLK          (CLK),
    .RESET_N      (RESET_N),
    .imem_addr    (imem_addr),
    .dmem_we      (dmem_we),
    .branch_taken (branch_taken)
);

// ==== dv/clk_gen.sv ====
`timescale 1ns/1ns

module clk_gen (
    output logic CLK,
    output logic RESET_N
);
    // 100 ns period
    initial begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;
    end

    // reset released on a falling edge after 10 cycles
    initial begin
        RESET_N = 1'b0;
        repeat (10) @(posedge CLK);
        @(negedge CLK);
        RESET_N = 1'b1;
    end

endmodule

// ==== logic/pipe_core.sv ====
`timescale 1ns/1ns

module pipe_core (
    input  logic                  CLK,
    input  logic                  RESET_N,
    output core_pkg::pc_t         imem_addr,
    input  riscv_isa_pkg::instr_t imem_data,
    output core_pkg::pc_t         dmem_addr,
    output core_pkg::word_t       dmem_wdata,
    output logic                  dmem_we,
    input  core_pkg::word_t       dmem_rdata
);
    import core_pkg::*;
    import riscv_isa_pkg::*;

    // fetch and decode stage
    pc_t      pc;
    pc_t      next_pc;
    reg_idx_t rs1;
    reg_idx_t rs2;
    reg_idx_t rd;
    word_t    imm;
    alu_op_e  alu_op;
    logic     use_imm;
    logic     reg_write;
    logic     mem_write;
    logic     branch;
    logic     branch_ne;
    wb_sel_e  wb_sel;
    word_t    rdata1;
    word_t    rdata2;

    // decode/execute register
    logic     id_ex_valid;
    alu_op_e  id_ex_alu_op;
    logic     id_ex_use_imm;
    logic     id_ex_reg_write;
    logic     id_ex_mem_write;
    logic     id_ex_branch;
    logic     id_ex_branch_ne;
    wb_sel_e  id_ex_wb_sel;
    pc_t      id_ex_pc;
    word_t    id_ex_rs1_data;
    word_t    id_ex_rs2_data;
    word_t    id_ex_imm;
    reg_idx_t id_ex_rd;

    // execute stage
    word_t    alu_b;
    word_t    alu_result;
    logic     alu_zero;
    logic     branch_taken;
    pc_t      branch_target;

    // execute/memory register
    logic     ex_mem_valid;
    logic     ex_mem_reg_write;
    logic     ex_mem_mem_write;
    wb_sel_e  ex_mem_wb_sel;
    word_t    ex_mem_alu_result;
    word_t    ex_mem_rs2_data;
    reg_idx_t ex_mem_rd;

    // memory/write-back register
    logic     mem_wb_valid;
    logic     mem_wb_reg_write;
    wb_sel_e  mem_wb_wb_sel;
    word_t    mem_wb_alu_result;
    word_t    mem_wb_mem_data;
    reg_idx_t mem_wb_rd;
    word_t    wb_data;
    logic     wb_we;

    assign next_pc   = branch_taken ? branch_target : pc + 32'd4;
    assign imem_addr = pc;

    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            pc <= RESET_PC;
        end else begin
            pc <= next_pc;
        end
    end

    decoder i_decoder (
        .instr     (imem_data),
        .rs1       (rs1),
        .rs2       (rs2),
        .rd        (rd),
        .imm       (imm),
        .alu_op    (alu_op),
        .use_imm   (use_imm),
        .reg_write (reg_write),
        .mem_write (mem_write),
        .branch    (branch),
        .branch_ne (branch_ne),
        .wb_sel    (wb_sel)
    );

    reg_file i_reg_file (
        .CLK     (CLK),
        .RESET_N (RESET_N),
        .rs1     (rs1),
        .rs2     (rs2),
        .rd      (mem_wb_rd),
        .wdata   (wb_data),
        .we      (wb_we),
        .rdata1  (rdata1),
        .rdata2  (rdata2)
    );

    // a taken branch turns the instruction in decode into a bubble
    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            id_ex_valid     <= 1'b0;
            id_ex_alu_op    <= ALU_ADD;
            id_ex_use_imm   <= 1'b0;
            id_ex_reg_write <= 1'b0;
            id_ex_mem_write <= 1'b0;
            id_ex_branch    <= 1'b0;
            id_ex_branch_ne <= 1'b0;
            id_ex_wb_sel    <= WB_ALU;
        end else if (branch_taken) begin
            id_ex_valid     <= 1'b0;
            id_ex_alu_op    <= ALU_ADD;
            id_ex_use_imm   <= 1'b0;
            id_ex_reg_write <= 1'b0;
            id_ex_mem_write <= 1'b0;
            id_ex_branch    <= 1'b0;
            id_ex_branch_ne <= 1'b0;
            id_ex_wb_sel    <= WB_ALU;
        end else begin
            id_ex_valid     <= 1'b1;
            id_ex_alu_op    <= alu_op;
            id_ex_use_imm   <= use_imm;
            id_ex_reg_write <= reg_write;
            id_ex_mem_write <= mem_write;
            id_ex_branch    <= branch;
            id_ex_branch_ne <= branch_ne;
            id_ex_wb_sel    <= wb_sel;
        end
    end

    always_ff @(posedge CLK) begin
        id_ex_pc       <= pc;
        id_ex_rs1_data <= rdata1;
        id_ex_rs2_data <= rdata2;
        id_ex_imm      <= imm;
        id_ex_rd       <= rd;
    end

    assign alu_b = id_ex_use_imm ? id_ex_imm : id_ex_rs2_data;

    alu i_alu (
        .a      (id_ex_rs1_data),
        .b      (alu_b),
        .op     (id_ex_alu_op),
        .result (alu_result),
        .zero   (alu_zero)
    );

    // BEQ takes on zero and BNE on nonzero
    assign branch_taken  = id_ex_valid && id_ex_branch && (alu_zero ^ id_ex_branch_ne);
    assign branch_target = id_ex_pc + id_ex_imm;

    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            ex_mem_valid     <= 1'b0;
            ex_mem_reg_write <= 1'b0;
            ex_mem_mem_write <= 1'b0;
            ex_mem_wb_sel    <= WB_ALU;
        end else begin
            ex_mem_valid     <= id_ex_valid;
            ex_mem_reg_write <= id_ex_reg_write;
            ex_mem_mem_write <= id_ex_mem_write;
            ex_mem_wb_sel    <= id_ex_wb_sel;
        end
    end

    always_ff @(posedge CLK) begin
        ex_mem_alu_result <= alu_result;
        ex_mem_rs2_data   <= id_ex_rs2_data;
        ex_mem_rd         <= id_ex_rd;
    end

    // data memory answers in the same cycle
    assign dmem_addr  = ex_mem_alu_result;
    assign dmem_wdata = ex_mem_rs2_data;
    assign dmem_we    = ex_mem_valid && ex_mem_mem_write;

    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            mem_wb_valid     <= 1'b0;
            mem_wb_reg_write <= 1'b0;
            mem_wb_wb_sel    <= WB_ALU;
        end else begin
            mem_wb_valid     <= ex_mem_valid;
            mem_wb_reg_write <= ex_mem_reg_write;
            mem_wb_wb_sel    <= ex_mem_wb_sel;
        end
    end

    always_ff @(posedge CLK) begin
        mem_wb_alu_result <= ex_mem_alu_result;
        mem_wb_mem_data   <= dmem_rdata;
        mem_wb_rd         <= ex_mem_rd;
    end

    assign wb_data = (mem_wb_wb_sel == WB_MEM) ? mem_wb_mem_data : mem_wb_alu_result;
    assign wb_we   = mem_wb_valid && mem_wb_reg_write;

endmodule

// ==== logic/alu.sv ====
`timescale 1ns/1ns

module alu (
    input  core_pkg::word_t   a,
    input  core_pkg::word_t   b,
    input  core_pkg::alu_op_e op,
    output core_pkg::word_t   result,
    output logic              zero
);
    import core_pkg::*;

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = b[4:0];
    assign lt_signed   = ($signed(a) < $signed(b));
    assign lt_unsigned = (a < b);

    always_comb begin
        case (op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_SLL:  result = a << shamt;
            ALU_SLT:  result = {{(XLEN-1){1'b0}}, lt_signed};
            ALU_SLTU: result = {{(XLEN-1){1'b0}}, lt_unsigned};
            ALU_XOR:  result = a ^ b;
            ALU_SRL:  result = a >> shamt;
            ALU_SRA:  result = $signed(a) >>> shamt;
            ALU_OR:   result = a | b;
            ALU_AND:  result = a & b;
            default:  result = '0;
        endcase
    end

    // branches read this after ALU_SUB
    assign zero = (result == '0);

endmodule

// ==== logic/decoder.sv ====
`timescale 1ns/1ns

module decoder (
    input  riscv_isa_pkg::instr_t   instr,
    output riscv_isa_pkg::reg_idx_t rs1,
    output riscv_isa_pkg::reg_idx_t rs2,
    output riscv_isa_pkg::reg_idx_t rd,
    output core_pkg::word_t         imm,
    output core_pkg::alu_op_e       alu_op,
    output logic                    use_imm,
    output logic                    reg_write,
    output logic                    mem_write,
    output logic                    branch,
    output logic                    branch_ne,
    output core_pkg::wb_sel_e       wb_sel
);
    import core_pkg::*;
    import riscv_isa_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       alt;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;

    // SUB only exists in R-type and SRA/SRAI in both forms
    function automatic alu_op_e alu_sel(input logic [2:0] f3, input logic sel_alt,
                                        input logic is_reg);
        case (f3)
            F3_ADD_SUB: return (is_reg && sel_alt) ? ALU_SUB : ALU_ADD;
            F3_SLL:     return ALU_SLL;
            F3_SLT:     return ALU_SLT;
            F3_SLTU:    return ALU_SLTU;
            F3_XOR:     return ALU_XOR;
            F3_SR:      return sel_alt ? ALU_SRA : ALU_SRL;
            F3_OR:      return ALU_OR;
            F3_AND:     return ALU_AND;
            default:    return ALU_ADD;
        endcase
    endfunction

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign alt    = (instr[31:25] == F7_ALT);
    assign rs2    = instr[24:20];
    assign rd     = instr[11:7];

    // sign-extended immediates per format
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};

    always_comb begin
        // defaults decode as a NOP
        rs1       = instr[19:15];
        imm       = imm_i;
        alu_op    = ALU_ADD;
        use_imm   = 1'b0;
        reg_write = 1'b0;
        mem_write = 1'b0;
        branch    = 1'b0;
        branch_ne = 1'b0;
        wb_sel    = WB_ALU;
        case (opcode)
            OP_REG: begin
                reg_write = 1'b1;
                alu_op    = alu_sel(funct3, alt, 1'b1);
            end
            OP_IMM: begin
                reg_write = 1'b1;
                use_imm   = 1'b1;
                alu_op    = alu_sel(funct3, alt, 1'b0);
            end
            OP_LOAD: begin
                reg_write = (funct3 == F3_LW_SW);
                use_imm   = 1'b1;
                wb_sel    = WB_MEM;
            end
            OP_STORE: begin
                mem_write = (funct3 == F3_LW_SW);
                use_imm   = 1'b1;
                imm       = imm_s;
            end
            OP_BRANCH: begin
                // compare by subtraction with the target added in execute
                branch    = (funct3 == F3_BEQ) || (funct3 == F3_BNE);
                branch_ne = (funct3 == F3_BNE);
                alu_op    = ALU_SUB;
                imm       = imm_b;
            end
            OP_LUI: begin
                // x0 as base gives imm + 0
                reg_write = 1'b1;
                use_imm   = 1'b1;
                rs1       = '0;
                imm       = imm_u;
            end
            default: ;
        endcase
    end

endmodule

// ==== logic/reg_file.sv ====
`timescale 1ns/1ns

module reg_file (
    input  logic                    CLK,
    input  logic                    RESET_N,
    input  riscv_isa_pkg::reg_idx_t rs1,
    input  riscv_isa_pkg::reg_idx_t rs2,
    input  riscv_isa_pkg::reg_idx_t rd,
    input  core_pkg::word_t         wdata,
    input  logic                    we,
    output core_pkg::word_t         rdata1,
    output core_pkg::word_t         rdata2
);
    import core_pkg::*;

    word_t regs [32];

    // x0 is never written so it stays at its reset value of zero
    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin
            regs[rd] <= wdata;
        end
    end

    // write-through so a read in the write cycle returns the new data
    assign rdata1 = (we && rd != '0 && rd == rs1) ? wdata : regs[rs1];
    assign rdata2 = (we && rd != '0 && rd == rs2) ? wdata : regs[rs2];

endmodule

// ==== logic/core_pkg.sv ====
package core_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [XLEN-1:0] pc_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

    // write-back source
    typedef enum logic {WB_ALU, WB_MEM} wb_sel_e;

    localparam pc_t RESET_PC = '0;

endpackage

// ==== logic/riscv_isa_pkg.sv ====
package riscv_isa_pkg;

    typedef logic [31:0] instr_t;
    typedef logic [4:0]  reg_idx_t;

    // major opcodes of the supported subset
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_LUI    = 7'b0110111;

    // ALU funct3
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SR      = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // branch funct3
    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;

    // word access only
    localparam logic [2:0] F3_LW_SW = 3'b010;

    // funct7 selecting SUB and SRA/SRAI
    localparam logic [6:0] F7_ALT = 7'b0100000;

endpackage
